/* include/cube_params.svh */
// cube drawing parameters
// coordinate, framebuffer and colour index sizes shared by package and RTL

`ifndef CUBE_PARAMS_SVH
`define CUBE_PARAMS_SVH

// signed coordinate width
`define CORDW 16

// framebuffer geometry in pixels
`define FB_WIDTH 640
`define FB_HEIGHT 360

// colour index width, 16 colour palette
`define CIDXW 4

// triangles in the cube table
`define SHAPE_CNT 6

`endif

/* src/cube_pkg.sv */
// cube drawing types
// vector typedefs and the decoder state encoding

package cube_pkg;

    `include "cube_params.svh"

    // signed pixel coordinate
    typedef logic signed [`CORDW-1:0] coord_t;

    // palette colour index
    typedef logic [`CIDXW-1:0] cidx_t;

    // linear framebuffer address, 18 bits for 640x360
    typedef logic [$clog2(`FB_WIDTH*`FB_HEIGHT)-1:0] fb_addr_t;

    // triangle number within the table
    typedef logic [2:0] shape_id_t;

    // shape decoder states
    typedef enum logic [1:0] {
        IDLE,
        INIT,
        DRAW,
        DONE
    } draw_state_e;

endpackage

/* src/draw_ifs.sv */
// drawing interfaces
// tri_if carries one triangle to the rasterizer, pix_if carries covered pixels

`timescale 1ns/10ps

interface tri_if import cube_pkg::*; ();
    coord_t x0, y0;  // vertex 0
    coord_t x1, y1;  // vertex 1
    coord_t x2, y2;  // vertex 2
    cidx_t  cidx;    // fill colour
    logic   start;   // one cycle, vertices valid
    logic   done;    // one cycle, triangle finished

    modport driver (
        output x0, y0, x1, y1, x2, y2, cidx, start,
        input  done
    );

    modport receiver (
        input  x0, y0, x1, y1, x2, y2, cidx, start,
        output done
    );
endinterface

interface pix_if import cube_pkg::*; ();
    logic   valid;  // one covered pixel this cycle
    coord_t x, y;
    cidx_t  cidx;

    modport driver (
        output valid, x, y, cidx
    );

    modport receiver (
        input  valid, x, y, cidx
    );
endinterface

/* src/shape_decoder.sv */
// shape decoder
// walks the six-triangle cube table once per reset, starting on a frame pulse

`timescale 1ns/10ps

module shape_decoder import cube_pkg::*; (
    input  logic  clk_pix,
    input  logic  rst_n,
    input  logic  frame,
    output logic  drawn,
    tri_if.driver tri_bus
);

    `include "cube_params.svh"

    draw_state_e state;
    shape_id_t   shape_id;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state         <= IDLE;
            shape_id      <= '0;
            tri_bus.start <= 1'b0;
        end else begin
            tri_bus.start <= 1'b0;  // pulse by default
            case (state)
                IDLE: if (frame) state <= INIT;
                INIT: begin
                    tri_bus.start <= 1'b1;  // entry loaded this edge
                    state         <= DRAW;
                end
                DRAW: if (tri_bus.done) begin
                    if (shape_id == shape_id_t'(`SHAPE_CNT - 1)) begin
                        state <= DONE;
                    end else begin
                        shape_id <= shape_id + 1'b1;
                        state    <= INIT;
                    end
                end
                default: state <= DONE;  // stays here until reset, frame ignored
            endcase
        end
    end

    assign drawn = (state == DONE);

    // triangle table, loaded in INIT and held until the next INIT
    always_ff @(posedge clk_pix) begin
        if (state == INIT) begin
            case (shape_id)
                3'd0: begin  // front right upper
                    tri_bus.x0   <= 16'sd260;
                    tri_bus.y0   <= 16'sd120;
                    tri_bus.x1   <= 16'sd460;
                    tri_bus.y1   <= 16'sd120;
                    tri_bus.x2   <= 16'sd460;
                    tri_bus.y2   <= 16'sd320;
                    tri_bus.cidx <= 4'h9;  // orange
                end
                3'd1: begin  // front right lower
                    tri_bus.x0   <= 16'sd260;
                    tri_bus.y0   <= 16'sd120;
                    tri_bus.x1   <= 16'sd460;
                    tri_bus.y1   <= 16'sd320;
                    tri_bus.x2   <= 16'sd260;
                    tri_bus.y2   <= 16'sd320;
                    tri_bus.cidx <= 4'hA;  // yellow
                end
                3'd2: begin  // left side lower
                    tri_bus.x0   <= 16'sd260;
                    tri_bus.y0   <= 16'sd120;
                    tri_bus.x1   <= 16'sd180;
                    tri_bus.y1   <= 16'sd240;
                    tri_bus.x2   <= 16'sd260;
                    tri_bus.y2   <= 16'sd320;
                    tri_bus.cidx <= 4'h2;  // dark purple
                end
                3'd3: begin  // left side upper
                    tri_bus.x0   <= 16'sd180;
                    tri_bus.y0   <= 16'sd40;
                    tri_bus.x1   <= 16'sd260;
                    tri_bus.y1   <= 16'sd120;
                    tri_bus.x2   <= 16'sd180;
                    tri_bus.y2   <= 16'sd240;
                    tri_bus.cidx <= 4'hE;  // pink
                end
                3'd4: begin  // top left
                    tri_bus.x0   <= 16'sd180;
                    tri_bus.y0   <= 16'sd40;
                    tri_bus.x1   <= 16'sd380;
                    tri_bus.y1   <= 16'sd40;
                    tri_bus.x2   <= 16'sd260;
                    tri_bus.y2   <= 16'sd120;
                    tri_bus.cidx <= 4'h1;  // dark blue
                end
                default: begin  // shape 5, top right
                    tri_bus.x0   <= 16'sd380;
                    tri_bus.y0   <= 16'sd40;
                    tri_bus.x1   <= 16'sd260;
                    tri_bus.y1   <= 16'sd120;
                    tri_bus.x2   <= 16'sd460;
                    tri_bus.y2   <= 16'sd120;
                    tri_bus.cidx <= 4'hC;  // blue
                end
            endcase
        end
    end

endmodule

/* src/triangle_raster.sv */
// triangle rasterizer
// scans the bounding box one pixel per cycle and flags pixels inside all three edges

`timescale 1ns/10ps

module triangle_raster import cube_pkg::*; (
    input  logic    clk_pix,
    input  logic    rst_n,
    input  logic    hold,
    tri_if.receiver tri_bus,
    pix_if.driver   pix
);

    `include "cube_params.svh"

    localparam int EW = 2 * `CORDW + 3;  // product of two 17-bit diffs plus a sign bit

    coord_t vx0, vy0, vx1, vy1, vx2, vy2;  // latched vertices
    cidx_t  cidx_r;
    coord_t xmin, xmax, ymax;  // box limits, ymin only needed at load
    coord_t px, py;            // pixel under test
    logic   busy;
    logic   step;              // test a pixel this cycle
    logic   last_col, last_row;
    logic   covered;
    logic signed [EW-1:0] e01, e12, e20;

    function automatic coord_t min3(coord_t a, coord_t b, coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic coord_t max3(coord_t a, coord_t b, coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    // (bx-ax)*(qy-ay) - (by-ay)*(qx-ax)
    function automatic logic signed [EW-1:0] edge_fn(
        coord_t ax, coord_t ay, coord_t bx, coord_t by, coord_t qx, coord_t qy
    );
        logic signed [`CORDW:0] dx_ab, dy_ab, dx_aq, dy_aq;
        dx_ab = bx - ax;  // 17-bit context, no overflow
        dy_ab = by - ay;
        dx_aq = qx - ax;
        dy_aq = qy - ay;
        return dx_ab * dy_aq - dy_ab * dx_aq;
    endfunction

    always_comb begin
        e01 = edge_fn(vx0, vy0, vx1, vy1, px, py);
        e12 = edge_fn(vx1, vy1, vx2, vy2, px, py);
        e20 = edge_fn(vx2, vy2, vx0, vy0, px, py);
        // either winding, edges included
        covered = (e01 >= 0 && e12 >= 0 && e20 >= 0) ||
                  (e01 <= 0 && e12 <= 0 && e20 <= 0);
    end

    assign step     = busy && !hold;  // frozen while framebuffer busy
    assign last_col = (px == xmax);
    assign last_row = (py == ymax);

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            busy         <= 1'b0;
            tri_bus.done <= 1'b0;
            pix.valid    <= 1'b0;
        end else begin
            tri_bus.done <= 1'b0;
            pix.valid    <= step && covered;
            if (tri_bus.start) begin
                busy <= 1'b1;
            end else if (step && last_col && last_row) begin
                busy         <= 1'b0;
                tri_bus.done <= 1'b1;  // lines up with the last pixel's valid
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (tri_bus.start) begin
            vx0    <= tri_bus.x0;
            vy0    <= tri_bus.y0;
            vx1    <= tri_bus.x1;
            vy1    <= tri_bus.y1;
            vx2    <= tri_bus.x2;
            vy2    <= tri_bus.y2;
            cidx_r <= tri_bus.cidx;
            xmin   <= min3(tri_bus.x0, tri_bus.x1, tri_bus.x2);
            xmax   <= max3(tri_bus.x0, tri_bus.x1, tri_bus.x2);
            ymax   <= max3(tri_bus.y0, tri_bus.y1, tri_bus.y2);
            px     <= min3(tri_bus.x0, tri_bus.x1, tri_bus.x2);
            py     <= min3(tri_bus.y0, tri_bus.y1, tri_bus.y2);
        end else if (step) begin
            if (last_col) begin  // wrap to next row
                px <= xmin;
                py <= py + 1'b1;
            end else begin
                px <= px + 1'b1;
            end
        end
        pix.x    <= px;
        pix.y    <= py;
        pix.cidx <= cidx_r;
    end

endmodule

/* src/fb_writer.sv */
// framebuffer writer
// one register stage from covered pixel to linear address, colour and write strobe

`timescale 1ns/10ps

module fb_writer import cube_pkg::*; (
    input  logic     clk_pix,
    input  logic     rst_n,
    pix_if.receiver  pix,
    output logic     pix_we,
    output fb_addr_t pix_addr,
    output cidx_t    pix_cidx
);

    `include "cube_params.svh"

    fb_addr_t row_base;
    fb_addr_t addr_next;

    // y * width + x, coordinates are never negative here
    always_comb begin
        row_base  = fb_addr_t'(pix.y) * fb_addr_t'(`FB_WIDTH);
        addr_next = row_base + fb_addr_t'(pix.x);
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            pix_we <= 1'b0;
        end else begin
            pix_we <= pix.valid;  // exactly one cycle behind valid
        end
    end

    always_ff @(posedge clk_pix) begin
        if (pix.valid) begin
            pix_addr <= addr_next;
            pix_cidx <= pix.cidx;
        end
    end

endmodule

/* src/cube_draw_top.sv */
// cube drawing top level
// decoder feeds the rasterizer, rasterizer feeds the framebuffer writer

`timescale 1ns/10ps

module cube_draw_top import cube_pkg::*; (
    input  logic     clk_pix,
    input  logic     rst_n,
    input  logic     frame,     // start of frame pulse
    input  logic     hold,      // framebuffer busy
    output logic     pix_we,
    output fb_addr_t pix_addr,
    output cidx_t    pix_cidx,
    output logic     drawn      // all six triangles finished
);

    tri_if tri_bus ();
    pix_if pix_bus ();

    shape_decoder u_shape_decoder (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .frame   (frame),
        .drawn   (drawn),
        .tri_bus (tri_bus)
    );

    triangle_raster u_triangle_raster (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .hold    (hold),
        .tri_bus (tri_bus),
        .pix     (pix_bus)
    );

    fb_writer u_fb_writer (
        .clk_pix  (clk_pix),
        .rst_n    (rst_n),
        .pix      (pix_bus),
        .pix_we   (pix_we),
        .pix_addr (pix_addr),
        .pix_cidx (pix_cidx)
    );

endmodule

/* tb/cube_draw_assertions.sv */
// cube drawing assertions
// bound into the rasterizer and the decoder to watch start, valid and drawn

`timescale 1ns/10ps

module cube_draw_assertions (
    input logic clk_pix,
    input logic rst_n,
    input logic start,
    input logic busy,
    input logic hold,
    input logic valid,
    input logic drawn
);

    // next triangle only once the previous box scan has ended
    start_when_idle: assert property (
        @(posedge clk_pix) disable iff (!rst_n) start |-> !busy
    ) else $error("start pulse while a triangle is still being scanned");

    // a frozen scan produces no pixel in the following cycle
    no_valid_after_hold: assert property (
        @(posedge clk_pix) disable iff (!rst_n) $past(hold) |-> !valid
    ) else $error("valid high in the cycle after hold was high");

    drawn_sticky: assert property (
        @(posedge clk_pix) disable iff (!rst_n) drawn |=> drawn
    ) else $error("drawn fell without a reset");

endmodule

bind triangle_raster cube_draw_assertions u_raster_checks (
    .clk_pix (clk_pix),
    .rst_n   (rst_n),
    .start   (tri_bus.start),
    .busy    (busy),
    .hold    (hold),
    .valid   (pix.valid),
    .drawn   (1'b0)         // decoder side only
);

bind shape_decoder cube_draw_assertions u_decoder_checks (
    .clk_pix (clk_pix),
    .rst_n   (rst_n),
    .start   (1'b0),        // raster side only
    .busy    (1'b0),
    .hold    (1'b0),
    .valid   (1'b0),
    .drawn   (drawn)
);

/* tb/cube_draw_tb.sv */
// cube drawing testbench
// checks every framebuffer write against a reference scan of the cube table

`timescale 1ns/10ps
`include "cube_params.svh"

module cube_draw_tb import cube_pkg::*; ();

    logic        clk_pix;
    logic        rst_n;
    logic        frame;
    logic        hold;
    logic        pix_we;
    fb_addr_t    pix_addr;
    cidx_t       pix_cidx;
    logic        drawn;

    // cube triangles, vertex columns 0..2
    int tri_x [`SHAPE_CNT][3] = '{'{260, 460, 460}, '{260, 460, 260}, '{260, 180, 260},
                                  '{180, 260, 180}, '{180, 380, 260}, '{380, 260, 460}};
    int tri_y [`SHAPE_CNT][3] = '{'{120, 120, 320}, '{120, 320, 320}, '{120, 240, 320},
                                  '{40, 120, 240}, '{40, 40, 120}, '{40, 120, 120}};
    cidx_t tri_c [`SHAPE_CNT] = '{4'h9, 4'hA, 4'h2, 4'hE, 4'h1, 4'hC};

    fb_addr_t    exp_addr [$];
    cidx_t       exp_cidx [$];
    int          box_area;     // sum of the six bounding boxes
    int          write_cnt;
    int          run_cycles;
    int          hold_cycles;
    logic        writes_open;  // a frame is being drawn
    logic        random_hold;
    logic        hold_d1, hold_d2;
    logic        first_bit;
    logic        ended;
    logic [31:0] lfsr;

    cube_draw_top u_cube_draw_top (
        .clk_pix  (clk_pix),
        .rst_n    (rst_n),
        .frame    (frame),
        .hold     (hold),
        .pix_we   (pix_we),
        .pix_addr (pix_addr),
        .pix_cidx (pix_cidx),
        .drawn    (drawn)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic longint edge_side(int ax, int ay, int bx, int by, int qx, int qy);
        return longint'(bx - ax) * longint'(qy - ay) - longint'(by - ay) * longint'(qx - ax);
    endfunction

    // ordered writes of all six triangles, row by row inside each box
    function automatic void expected_pixels();
        int     lo_x, hi_x, lo_y, hi_y;
        longint s0, s1, s2;
        exp_addr.delete();
        exp_cidx.delete();
        box_area = 0;
        for (int t = 0; t < `SHAPE_CNT; t++) begin
            lo_x = tri_x[t][0];
            hi_x = lo_x;
            lo_y = tri_y[t][0];
            hi_y = lo_y;
            for (int v = 1; v < 3; v++) begin
                if (tri_x[t][v] < lo_x) lo_x = tri_x[t][v];
                if (tri_x[t][v] > hi_x) hi_x = tri_x[t][v];
                if (tri_y[t][v] < lo_y) lo_y = tri_y[t][v];
                if (tri_y[t][v] > hi_y) hi_y = tri_y[t][v];
            end
            box_area += (hi_x - lo_x + 1) * (hi_y - lo_y + 1);
            for (int y = lo_y; y <= hi_y; y++) begin
                for (int x = lo_x; x <= hi_x; x++) begin
                    s0 = edge_side(tri_x[t][0], tri_y[t][0], tri_x[t][1], tri_y[t][1], x, y);
                    s1 = edge_side(tri_x[t][1], tri_y[t][1], tri_x[t][2], tri_y[t][2], x, y);
                    s2 = edge_side(tri_x[t][2], tri_y[t][2], tri_x[t][0], tri_y[t][0], x, y);
                    if ((s0 >= 0 && s1 >= 0 && s2 >= 0) || (s0 <= 0 && s1 <= 0 && s2 <= 0)) begin
                        exp_addr.push_back(fb_addr_t'(y * `FB_WIDTH + x));
                        exp_cidx.push_back(tri_c[t]);
                    end
                end
            end
        end
    endfunction

    task automatic abort_run(string reason);
        $display("%s", reason);
        ended = 1'b1;
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_addr(fb_addr_t expected, fb_addr_t actual);
        if (actual !== expected)
            abort_run($sformatf("error at %0t: pix_addr expected %0d got %0d",
                                $time, expected, actual));
    endtask

    task automatic check_cidx(cidx_t expected, cidx_t actual);
        if (actual !== expected)
            abort_run($sformatf("error at %0t: pix_cidx expected %0h got %0h",
                                $time, expected, actual));
    endtask

    task automatic check_count(int expected, int actual);
        if (actual != expected)
            abort_run($sformatf("error at %0t: pix_we count expected %0d got %0d",
                                $time, expected, actual));
    endtask

    task automatic apply_reset();
        @(posedge clk_pix);
        #2;
        rst_n       = 1'b0;
        writes_open = 1'b0;
        write_cnt   = 0;
        repeat (4) @(posedge clk_pix);
        #2;
        rst_n = 1'b1;
    endtask

    task automatic pulse_frame();
        @(posedge clk_pix);
        #2;
        frame = 1'b1;
        @(posedge clk_pix);
        #2;
        frame = 1'b0;
    endtask

    task automatic draw_and_check();
        writes_open = 1'b1;
        write_cnt   = 0;
        pulse_frame();
        while (!drawn) @(negedge clk_pix);  // watchdog bounds this wait
        @(posedge clk_pix);                 // every write up to the rise of drawn is counted
        check_count(exp_addr.size(), write_cnt);
        writes_open = 1'b0;
        pulse_frame();  // ignored once drawn
        repeat (50) begin
            @(negedge clk_pix);
            if (!drawn) abort_run("drawn fell without a reset");
        end
    endtask

    initial begin
        clk_pix = 1'b0;
        forever #10 clk_pix = ~clk_pix;
    end

    // hold stimulus, high when two fresh LFSR bits are both one
    always @(posedge clk_pix) begin
        #2;
        if (random_hold) begin
            lfsr      = lfsr_step(lfsr);
            first_bit = lfsr[0];
            lfsr      = lfsr_step(lfsr);
            hold      = first_bit & lfsr[0];
        end else begin
            hold = 1'b0;
        end
    end

    // compare each write with the next reference entry
    always @(negedge clk_pix) begin
        if (rst_n && pix_we) begin
            if (!writes_open) abort_run("pix_we high while no frame was being drawn");
            if (hold_d2) abort_run("pix_we high more than one cycle after hold rose");
            if (write_cnt >= exp_addr.size()) abort_run("more writes than covered pixels");
            check_addr(exp_addr[write_cnt], pix_addr);
            check_cidx(exp_cidx[write_cnt], pix_cidx);
            write_cnt++;
        end
        hold_d2 = hold_d1;
        hold_d1 = hold;
    end

    // two drawing runs, each allowed 1.5 times the box area
    always @(posedge clk_pix) begin
        run_cycles++;
        if (hold) hold_cycles++;
        if (box_area > 0 && run_cycles > 3 * box_area + hold_cycles + 2000)
            abort_run("timeout, the cube was not drawn in time");
    end

    initial begin
        rst_n       = 1'b0;
        frame       = 1'b0;
        hold        = 1'b0;
        random_hold = 1'b0;
        lfsr        = 32'h7e51;
        writes_open = 1'b0;
        write_cnt   = 0;
        run_cycles  = 0;
        hold_cycles = 0;
        hold_d1     = 1'b0;
        hold_d2     = 1'b0;
        first_bit   = 1'b0;
        ended       = 1'b0;
        expected_pixels();

        random_hold = 1'b1;  // idle outputs must ignore hold
        apply_reset();
        repeat (50) begin
            @(negedge clk_pix);
            if (pix_we || drawn) abort_run("pix_we or drawn high before any frame pulse");
        end

        random_hold = 1'b0;
        draw_and_check();

        random_hold = 1'b1;  // same writes expected under back-pressure
        apply_reset();
        draw_and_check();

        ended = 1'b1;
        $display("All checks passed");
        $finish;
    end

    // run stopped by an assertion
    final begin
        if (!ended) $display("Checks failed");
    end

endmodule

/* files.f */
+incdir+include
src/cube_pkg.sv
src/draw_ifs.sv
src/shape_decoder.sv
src/triangle_raster.sv
src/fb_writer.sv
src/cube_draw_top.sv
tb/cube_draw_assertions.sv
tb/cube_draw_tb.sv

/* Makefile */
# Verilator simulation of the cube drawing testbench
# override from the command line, e.g. make sim TOP=cube_draw_tb LOG=run.log

TOP      ?= cube_draw_tb
LOG      ?= sim.log
OBJ_DIR  ?= obj_dir
VFLAGS   ?= --binary --timing --assert -j 0
PASS_MSG ?= All checks passed

.PHONY: sim clean

sim:
	verilator $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f files.f
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
